//--- verilog/comb_cfg.svh
// Comb filter configuration
`ifndef COMB_CFG_SVH
`define COMB_CFG_SVH

//////////////////////////////////////////////////
// Sample arithmetic
//////////////////////////////////////////////////

`define COMB_N_BITS          16   // Sample width
`define COMB_Q_BITS          14   // Gain fraction bits, Q2.14

//////////////////////////////////////////////////
// Delay line in external memory
//////////////////////////////////////////////////

// Must be a multiple of COMB_PREFETCH_WORDS
`define COMB_DEPTH           256
`define COMB_MIN_DELAY       40   // Keeps writes ahead of the next prefetch
`define COMB_BASE_ADDR       32'h0000_1000

//////////////////////////////////////////////////
// Memory port
//////////////////////////////////////////////////

`define COMB_MEM_ADDR_W      32
`define COMB_MEM_DATA_W      64   // One beat
`define COMB_WORDS_PER_BEAT  4    // Samples per beat
`define COMB_PREFETCH_WORDS  32   // Also the FIFO depth
`define COMB_PREFETCH_LEN    7    // Beats minus one, 64 bytes

`endif

//--- verilog/comb_pkg.sv
// Comb filter types
`include "comb_cfg.svh"

package comb_pkg;

  //////////////////////////////////////////////////
  // Scalar types
  //////////////////////////////////////////////////

  typedef logic signed [`COMB_N_BITS-1:0]        sample_t;    // Audio sample
  typedef logic signed [`COMB_N_BITS-1:0]        gain_t;      // Q2.14
  typedef logic [$clog2(`COMB_DEPTH)-1:0]        word_addr_t; // Delay line index
  typedef logic [`COMB_MEM_ADDR_W-1:0]           mem_addr_t;  // Byte address
  typedef logic [`COMB_MEM_DATA_W-1:0]           mem_data_t;  // One beat

  //////////////////////////////////////////////////
  // Memory channel payloads
  //////////////////////////////////////////////////

  // Write address, single beat burst
  typedef struct packed {
    mem_addr_t addr;
  } mem_aw_t;

  // Write data, all strobes on
  typedef struct packed {
    mem_data_t data;
  } mem_w_t;

  // Read address
  typedef struct packed {
    mem_addr_t  addr;
    logic [7:0] len;  // Beats minus one
  } mem_ar_t;

  // Read data
  typedef struct packed {
    mem_data_t data;
    logic      last; // Final beat of the burst
  } mem_r_t;

endpackage

//--- verilog/sync_fifo.sv
// Synchronous FIFO, first word fall through
module sync_fifo #(
  parameter int DATA_W = 16, // Word width
  parameter int ADDR_W = 5   // Depth is 2**ADDR_W
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clear,
  input  logic              push,
  input  logic [DATA_W-1:0] push_data,
  input  logic              pop,
  output logic [DATA_W-1:0] pop_data,
  output logic              empty,
  output logic              full
);

  localparam int DEPTH = 2 ** ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];
  logic [ADDR_W:0]   wr_idx; // Extra bit tells full from empty
  logic [ADDR_W:0]   rd_idx;
  logic              do_push;
  logic              do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_idx <= '0;
      rd_idx <= '0;
    end else if (clear) begin
      wr_idx <= '0; // Clear beats a same-cycle push
      rd_idx <= '0;
    end else begin
      if (do_push) wr_idx <= wr_idx + 1'b1;
      if (do_pop)  rd_idx <= rd_idx + 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (do_push && !clear) mem[wr_idx[ADDR_W-1:0]] <= push_data;
  end

  assign pop_data = mem[rd_idx[ADDR_W-1:0]]; // Head visible without a pop
  assign empty    = (wr_idx == rd_idx);
  assign full     = (wr_idx[ADDR_W] != rd_idx[ADDR_W]) &&
                    (wr_idx[ADDR_W-1:0] == rd_idx[ADDR_W-1:0]);

endmodule

//--- verilog/comb_core.sv
// Comb filter core
`include "comb_cfg.svh"

module comb_core
  import comb_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // Sample stream
  input  sample_t    x,
  input  logic       x_valid,
  output sample_t    y,
  output logic       y_valid,
  // Configuration
  input  logic       cmd_set_delay,
  input  word_addr_t cr_delay,
  input  gain_t      cr_gain,
  output logic       clear,
  // Delay line write
  output logic       wr_req,
  output word_addr_t wr_ptr,
  output sample_t    wr_data,
  input  logic       wr_busy,
  // Delay line read
  output logic       rd_req,
  output word_addr_t rd_ptr,
  input  sample_t    rd_data,
  input  logic       rd_valid,
  output logic       rd_pop
);

  localparam int N = `COMB_N_BITS;

  typedef enum logic [2:0] {
    s_idle,
    s_request,
    s_wait_data,
    s_compute,
    s_write
  } core_state_t;

  core_state_t state;

  sample_t x_q;    // Latched input
  sample_t d_q;    // Delayed word y(n-D)
  gain_t   gain_q;

  logic signed [2*N-1:0] prod;
  logic signed [2*N:0]   sum;   // Wide enough for any x + g*d
  sample_t               y_sat;

  //////////////////////////////////////////////////
  // Multiply, floor shift, saturate
  //////////////////////////////////////////////////

  always_comb begin
    prod = gain_q * d_q;
    sum  = x_q + (prod >>> `COMB_Q_BITS); // Arithmetic shift rounds toward minus infinity
    if (sum[2*N:N-1] != {(N+2){sum[2*N]}}) begin // Upper bits disagree, out of range
      y_sat = sum[2*N] ? {1'b1, {(N-1){1'b0}}} : {1'b0, {(N-1){1'b1}}};
    end else begin
      y_sat = sum[N-1:0];
    end
  end

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= s_idle;
      rd_ptr  <= '0;
      wr_ptr  <= word_addr_t'(`COMB_MIN_DELAY);
      gain_q  <= '0;
      y_valid <= 1'b0;
      clear   <= 1'b0;
    end else begin
      y_valid <= 1'b0;
      clear   <= cmd_set_delay; // FIFO and packer flush
      case (state)
        s_idle: begin
          if (cmd_set_delay) begin
            rd_ptr <= '0;
            wr_ptr <= cr_delay; // Write leads read by D
            gain_q <= cr_gain;
          end
          if (x_valid) state <= s_request;
        end
        s_request:   state <= s_wait_data;             // rd_req out this cycle
        s_wait_data: if (rd_valid) state <= s_compute;
        s_compute:   state <= s_write;
        s_write: begin
          // Hold here while the bridge drains a full beat
          if (!wr_busy) begin
            rd_ptr  <= rd_ptr + 1'b1; // Wraps at depth
            wr_ptr  <= wr_ptr + 1'b1;
            y_valid <= 1'b1;
            state   <= s_idle;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge clk) begin
    if (state == s_idle && x_valid) x_q <= x;
    if (rd_pop) d_q <= rd_data;
    if (state == s_compute) y <= y_sat;
  end

  assign rd_req  = (state == s_request);
  assign rd_pop  = (state == s_wait_data) && rd_valid; // FIFO head is the word
  assign wr_req  = (state == s_write) && !wr_busy;
  assign wr_data = y;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Source must wait for the previous y_valid
  a_x_in_idle : assert property (@(posedge clk) disable iff (!rst_n)
    x_valid |-> state == s_idle)
    else $error("x_valid while a sample is still in flight");

  // Beat aligned delay, long enough for the prefetch to see written data
  a_delay_cfg : assert property (@(posedge clk) disable iff (!rst_n)
    cmd_set_delay |-> state == s_idle && cr_delay[1:0] == 2'b00 &&
                      cr_delay >= word_addr_t'(`COMB_MIN_DELAY))
    else $error("delay set while busy or with an illegal value");

endmodule

//--- verilog/comb_mem_bridge.sv
// Delay line memory bridge
`include "comb_cfg.svh"

module comb_mem_bridge
  import comb_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       clear,
  // Core write side
  input  logic       wr_req,
  input  word_addr_t wr_ptr,
  input  sample_t    wr_data,
  output logic       wr_busy,
  // Core read side
  input  logic       rd_req,
  input  word_addr_t rd_ptr,
  // FIFO fill
  output logic       push,
  output sample_t    push_data,
  // Memory channels
  output mem_aw_t    aw,
  output logic       awvalid,
  input  logic       awready,
  output mem_w_t     w,
  output logic       wvalid,
  input  logic       wready,
  input  logic       bvalid,
  output logic       bready,
  output mem_ar_t    ar,
  output logic       arvalid,
  input  logic       arready,
  input  mem_r_t     r,
  input  logic       rvalid,
  output logic       rready
);

  localparam int N       = `COMB_N_BITS;
  localparam int PF_BITS = $clog2(`COMB_PREFETCH_WORDS);
  localparam int BURST_B = $clog2(`COMB_PREFETCH_WORDS * N / 8); // Burst byte alignment

  typedef enum logic [1:0] {ws_collect, ws_address, ws_data} wr_state_t;
  typedef enum logic [1:0] {rs_idle, rs_address, rs_data, rs_unpack} rd_state_t;

  wr_state_t wr_state;
  rd_state_t rd_state;

  logic [1:0]        wr_cnt;     // Words packed so far
  logic [1:0]        unpack_cnt; // Word of the beat being pushed
  mem_data_t         rd_beat;
  logic              rd_last;
  logic              rd_drop;    // Draining a burst cut off by clear
  logic              rd_pend;    // Aligned request seen while busy
  word_addr_t        pend_ptr;
  logic              rd_start;
  word_addr_t        start_ptr;
  logic [3:0]        b_pend;     // Writes awaiting response
  logic signed [6:0] shadow_fill;

  //////////////////////////////////////////////////
  // Write packer
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_state <= ws_collect;
      wr_cnt   <= '0;
    end else begin
      case (wr_state)
        ws_collect: if (wr_req) begin
          wr_cnt <= wr_cnt + 1'b1;
          if (wr_cnt == 2'd3) wr_state <= ws_address; // Beat complete
        end
        ws_address: if (awready) wr_state <= ws_data;
        ws_data:    if (wready) wr_state <= ws_collect;
        default:    wr_state <= ws_collect;
      endcase
      if (clear) wr_cnt <= '0; // Partial beat dropped
    end
  end

  // Beat and address, lowest address in the low lane
  always_ff @(posedge clk) begin
    if (wr_state == ws_collect && wr_req) begin
      w.data[wr_cnt*N +: N] <= wr_data;
      if (wr_cnt == 2'd0) aw.addr <= `COMB_BASE_ADDR + {wr_ptr, 1'b0};
    end
  end

  assign awvalid = (wr_state == ws_address);
  assign wvalid  = (wr_state == ws_data);
  assign wr_busy = (wr_state != ws_collect);
  assign bready  = 1'b1;

  //////////////////////////////////////////////////
  // Prefetch reader
  //////////////////////////////////////////////////

  assign rd_start  = rd_pend || (rd_req && rd_ptr[PF_BITS-1:0] == '0);
  assign start_ptr = rd_pend ? pend_ptr : rd_ptr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_state   <= rs_idle;
      unpack_cnt <= '0;
      rd_drop    <= 1'b0;
      rd_pend    <= 1'b0;
      pend_ptr   <= '0;
    end else begin
      case (rd_state)
        rs_idle: begin
          rd_drop <= 1'b0;
          if (rd_start) begin
            rd_pend  <= 1'b0;
            rd_state <= rs_address;
          end
        end
        rs_address: if (arready) rd_state <= rs_data;
        rs_data: if (rvalid) begin
          unpack_cnt <= '0;
          rd_state   <= rs_unpack;
        end
        rs_unpack: begin
          unpack_cnt <= unpack_cnt + 1'b1;
          if (unpack_cnt == 2'd3) rd_state <= rd_last ? rs_idle : rs_data;
        end
        default: rd_state <= rs_idle;
      endcase
      // Request right after a flush, burst still in flight
      if (rd_state != rs_idle && rd_req && rd_ptr[PF_BITS-1:0] == '0) begin
        rd_pend  <= 1'b1;
        pend_ptr <= rd_ptr;
      end
      if (clear && rd_state != rs_idle) rd_drop <= 1'b1; // Finish burst, push nothing
    end
  end

  always_ff @(posedge clk) begin
    if (rd_state == rs_idle && rd_start) begin
      ar.addr <= `COMB_BASE_ADDR + {start_ptr, 1'b0};
      ar.len  <= 8'(`COMB_PREFETCH_LEN);
    end
    if (rd_state == rs_data && rvalid) begin
      rd_beat <= r.data;
      rd_last <= r.last;
    end
  end

  assign arvalid   = (rd_state == rs_address);
  assign rready    = (rd_state == rs_data); // Low during unpack
  assign push      = (rd_state == rs_unpack) && !rd_drop;
  assign push_data = rd_beat[unpack_cnt*N +: N];

  //////////////////////////////////////////////////
  // Bookkeeping for checks
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      b_pend      <= '0;
      shadow_fill <= '0;
    end else begin
      b_pend <= b_pend + 4'(wvalid && wready) - 4'(bvalid && bready);
      if (clear) begin
        shadow_fill <= '0;
      end else begin
        shadow_fill <= shadow_fill + 7'(push) - 7'(rd_req); // One pop per request
      end
    end
  end

  a_ar_aligned : assert property (@(posedge clk) disable iff (!rst_n)
    arvalid |-> ar.addr[BURST_B-1:0] == '0)
    else $error("read burst address not 64-byte aligned");

  // Pushes never run a full burst ahead of the core's requests
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    push |-> shadow_fill < 7'(`COMB_PREFETCH_WORDS))
    else $error("prefetch push would overflow the FIFO");

  a_b_expected : assert property (@(posedge clk) disable iff (!rst_n)
    bvalid |-> b_pend != '0)
    else $error("write response without an outstanding write");

endmodule

//--- verilog/iir_comb_top.sv
// Comb filter with external delay line
`include "comb_cfg.svh"

module iir_comb_top
  import comb_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // Samples
  input  sample_t    x,
  input  logic       x_valid,
  output sample_t    y,
  output logic       y_valid,
  // Configuration
  input  logic       cmd_set_delay,
  input  word_addr_t cr_delay,
  input  gain_t      cr_gain,
  // Memory master
  output mem_aw_t    aw,
  output logic       awvalid,
  input  logic       awready,
  output mem_w_t     w,
  output logic       wvalid,
  input  logic       wready,
  input  logic       bvalid,
  output logic       bready,
  output mem_ar_t    ar,
  output logic       arvalid,
  input  logic       arready,
  input  mem_r_t     r,
  input  logic       rvalid,
  output logic       rready
);

  //////////////////////////////////////////////////
  // Internal links
  //////////////////////////////////////////////////

  logic       clear;
  logic       wr_req;
  word_addr_t wr_ptr;
  sample_t    wr_data;
  logic       wr_busy;
  logic       rd_req;
  word_addr_t rd_ptr;
  logic       push;
  sample_t    push_data;
  sample_t    fifo_data;
  logic       fifo_empty;
  logic       rd_pop;
  logic       rd_valid;

  assign rd_valid = !fifo_empty; // Head word ready for the core

  comb_core i_comb_core (
    .clk           (clk),
    .rst_n         (rst_n),
    .x             (x),
    .x_valid       (x_valid),
    .y             (y),
    .y_valid       (y_valid),
    .cmd_set_delay (cmd_set_delay),
    .cr_delay      (cr_delay),
    .cr_gain       (cr_gain),
    .clear         (clear),
    .wr_req        (wr_req),
    .wr_ptr        (wr_ptr),
    .wr_data       (wr_data),
    .wr_busy       (wr_busy),
    .rd_req        (rd_req),
    .rd_ptr        (rd_ptr),
    .rd_data       (fifo_data),
    .rd_valid      (rd_valid),
    .rd_pop        (rd_pop)
  );

  comb_mem_bridge i_comb_mem_bridge (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (clear),
    .wr_req    (wr_req),
    .wr_ptr    (wr_ptr),
    .wr_data   (wr_data),
    .wr_busy   (wr_busy),
    .rd_req    (rd_req),
    .rd_ptr    (rd_ptr),
    .push      (push),
    .push_data (push_data),
    .aw        (aw),
    .awvalid   (awvalid),
    .awready   (awready),
    .w         (w),
    .wvalid    (wvalid),
    .wready    (wready),
    .bvalid    (bvalid),
    .bready    (bready),
    .ar        (ar),
    .arvalid   (arvalid),
    .arready   (arready),
    .r         (r),
    .rvalid    (rvalid),
    .rready    (rready)
  );

  // Holds one prefetch burst
  sync_fifo #(
    .DATA_W ($bits(sample_t)),
    .ADDR_W ($clog2(`COMB_PREFETCH_WORDS))
  ) i_sync_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (clear),
    .push      (push),
    .push_data (push_data),
    .pop       (rd_pop),
    .pop_data  (fifo_data),
    .empty     (fifo_empty),
    .full      ()
  );

endmodule

//--- verif/comb_mem_model.sv
// Delay line memory model
`include "comb_cfg.svh"

module comb_mem_model
  import comb_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  // Write channels
  input  mem_aw_t aw,
  input  logic    awvalid,
  output logic    awready,
  input  mem_w_t  w,
  input  logic    wvalid,
  output logic    wready,
  output logic    bvalid,
  input  logic    bready,
  // Read channels
  input  mem_ar_t ar,
  input  logic    arvalid,
  output logic    arready,
  output mem_r_t  r,
  output logic    rvalid,
  input  logic    rready
);

  localparam int BYTES = 2 * `COMB_DEPTH;               // 512 bytes of delay line
  localparam int BEATS = BYTES / (`COMB_MEM_DATA_W / 8);

  mem_data_t mem [BEATS];
  int        seed;
  mem_addr_t wr_addr;   // Address of the pending write beat
  logic      aw_have;   // Address taken, data still to come
  int        b_owed;    // Responses not yet given
  int        wr_idx;
  int        rd_idx;
  mem_ar_t   burst;     // Read burst being served
  logic      rd_active;
  int        r_count;   // Beats taken so far
  int        offer_idx; // Beat now on the r channel

  // Beat slot for a byte address, -1 when outside the window
  function automatic int beat_index(mem_addr_t a);
    mem_addr_t off;
    off = a - `COMB_BASE_ADDR;
    if (a < `COMB_BASE_ADDR || off >= mem_addr_t'(BYTES)) return -1;
    return int'(off >> 3);
  endfunction

  // True three times in four
  function automatic logic coin();
    return ($random(seed) & 3) != 0;
  endfunction

  initial begin
    seed    = 35677;
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    arready = 1'b0;
    rvalid  = 1'b0;
    r       = '0;
    for (int i = 0; i < BEATS; i++) begin
      mem[i] = '0; // Memory starts blank
    end
  end

  //////////////////////////////////////////////////
  // Transfers on the rising edge
  //////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aw_have   <= 1'b0;
      b_owed    <= 0;
      rd_active <= 1'b0;
      r_count   <= 0;
    end else begin
      if (awvalid && awready) begin
        wr_addr <= aw.addr;
        aw_have <= 1'b1;
      end
      if (wvalid && wready) begin
        wr_idx = beat_index(wr_addr);
        if (wr_idx >= 0) mem[wr_idx] = w.data; // Out of range writes dropped
        aw_have <= 1'b0;
      end
      b_owed <= b_owed + int'(wvalid && wready) - int'(bvalid && bready);
      if (arvalid && arready) begin
        burst     <= ar;
        rd_active <= 1'b1;
        r_count   <= 0;
      end
      if (rvalid && rready) begin
        r_count <= r_count + 1;
        if (r.last) rd_active <= 1'b0; // Burst done
      end
    end
  end

  //////////////////////////////////////////////////
  // Ready and valid gaps, driven on the falling edge
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst_n) begin
      awready = 1'b0;
      wready  = 1'b0;
      bvalid  = 1'b0;
      arready = 1'b0;
      rvalid  = 1'b0;
    end else begin
      awready = !aw_have && coin();
      wready  = aw_have && coin();
      bvalid  = (b_owed != 0);
      arready = !rd_active && coin();
      // Beat still on offer holds with its payload
      if (!(rvalid && r_count == offer_idx)) begin
        rvalid = 1'b0;
        if (rd_active && coin()) begin
          offer_idx = r_count;
          rd_idx    = beat_index(burst.addr + mem_addr_t'(8 * r_count));
          r.data    = (rd_idx >= 0) ? mem[rd_idx] : '0;
          r.last    = (r_count == int'(burst.len));
          rvalid    = 1'b1;
        end
      end
    end
  end

endmodule

//--- verif/tb_iir_comb.sv
// Comb filter testbench
`include "comb_cfg.svh"

module tb_iir_comb
  import comb_pkg::*;
();

  localparam int      NUM_CASES   = 5;
  localparam int      CYCLES_EACH = 200;        // Watchdog budget per sample
  localparam sample_t S_MAX       = 16'sh7fff;
  localparam sample_t S_MIN       = 16'sh8000;  // Most negative

  typedef struct packed {
    word_addr_t  delay;
    gain_t       gain;   // Q2.14
    logic [15:0] count;  // Multiple of 4
    sample_t     amp;
    logic        sat;    // Full-scale input with alternating sign
  } case_t;

  logic       clk;
  logic       rst_n;
  sample_t    x;
  logic       x_valid;
  sample_t    y;
  logic       y_valid;
  logic       cmd_set_delay;
  word_addr_t cr_delay;
  gain_t      cr_gain;
  mem_aw_t    aw;
  logic       awvalid;
  logic       awready;
  mem_w_t     w;
  logic       wvalid;
  logic       wready;
  logic       bvalid;
  logic       bready;
  mem_ar_t    ar;
  logic       arvalid;
  logic       arready;
  mem_r_t     r;
  logic       rvalid;
  logic       rready;

  case_t      cases [NUM_CASES];
  sample_t    mirror [`COMB_DEPTH]; // Reference copy of the delay line
  word_addr_t ref_rd;
  word_addr_t ref_wr;
  gain_t      ref_gain;
  int         seed;
  int         sample_errors;
  int         addr_errors;
  int         other_errors;
  int         sat_hi;
  int         sat_lo;

  iir_comb_top i_iir_comb_top (
    .clk (clk), .rst_n (rst_n),
    .x (x), .x_valid (x_valid), .y (y), .y_valid (y_valid),
    .cmd_set_delay (cmd_set_delay), .cr_delay (cr_delay), .cr_gain (cr_gain),
    .aw (aw), .awvalid (awvalid), .awready (awready),
    .w (w), .wvalid (wvalid), .wready (wready),
    .bvalid (bvalid), .bready (bready),
    .ar (ar), .arvalid (arvalid), .arready (arready),
    .r (r), .rvalid (rvalid), .rready (rready)
  );

  comb_mem_model i_comb_mem_model (
    .clk (clk), .rst_n (rst_n),
    .aw (aw), .awvalid (awvalid), .awready (awready),
    .w (w), .wvalid (wvalid), .wready (wready),
    .bvalid (bvalid), .bready (bready),
    .ar (ar), .arvalid (arvalid), .arready (arready),
    .r (r), .rvalid (rvalid), .rready (rready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Case table and reference
  //////////////////////////////////////////////////

  task automatic load_cases();
    // delay, gain, count, amplitude, saturate
    cases[0] = '{8'd64, 16'sd8192, 16'd96, 16'sd8000, 1'b0};      // Pass-through then echo
    cases[1] = '{8'd40, 16'sd31130, 16'd160, 16'sd30000, 1'b1};   // Gain near 1.9 drives clipping
    cases[2] = '{8'd128, -16'sd12000, 16'd600, 16'sd6000, 1'b0};  // Several wraps
    cases[3] = '{8'd252, 16'sd16000, 16'd400, 16'sd10000, 1'b0};  // Longest delay
    cases[4] = '{8'd100, -16'sd31000, 16'd320, 16'sd12000, 1'b0}; // Stale words after change
  endtask

  // y = x + floor(g * d / 2^14), clipped to 16 bits
  function automatic sample_t expected_output(sample_t xs, sample_t d, gain_t g);
    int prod;
    int sum;
    prod = int'(g) * int'(d);
    sum  = int'(xs) + (prod >>> `COMB_Q_BITS);
    if (sum > 32767) sum = 32767;
    else if (sum < -32768) sum = -32768;
    return sample_t'(sum);
  endfunction

  task automatic check_sample(sample_t got, sample_t exp, string what);
    if (got !== exp) begin
      sample_errors++;
      $display("Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Whole beat or burst must lie inside the window and be aligned to its span
  task automatic check_addr(mem_addr_t addr, mem_addr_t span, string kind);
    mem_addr_t lo;
    mem_addr_t hi;
    lo = `COMB_BASE_ADDR;
    hi = lo + mem_addr_t'(2 * `COMB_DEPTH);
    if (addr < lo || addr + span > hi) begin
      addr_errors++;
      $display("The %s address %h at time %0t lies outside the delay line window",
               kind, addr, $time);
    end
    if ((addr & (span - 1)) != '0) begin
      addr_errors++;
      $display("The %s address %h at time %0t is not aligned to %0d bytes",
               kind, addr, $time, span);
    end
  endtask

  task automatic apply_config(input case_t c);
    cr_delay      = c.delay;
    cr_gain       = c.gain;
    cmd_set_delay = 1'b1;
    @(negedge clk);
    cmd_set_delay = 1'b0;
    repeat (2) @(negedge clk); // Clear pulse passes
    ref_rd   = '0;
    ref_wr   = c.delay;        // Same pointer rule as the filter
    ref_gain = c.gain;
  endtask

  // Drives one sample and returns on y_valid
  task automatic drive_sample(input sample_t xs);
    x       = xs;
    x_valid = 1'b1;
    @(negedge clk);
    x_valid = 1'b0;
    while (!y_valid) begin
      @(negedge clk);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    case_t   c;
    sample_t xs;
    sample_t exp;
    seed          = 35677;
    sample_errors = 0;
    addr_errors   = 0;
    other_errors  = 0;
    x             = '0;
    x_valid       = 1'b0;
    cmd_set_delay = 1'b0;
    cr_delay      = '0;
    cr_gain       = '0;
    rst_n         = 1'b0;
    load_cases();
    for (int i = 0; i < `COMB_DEPTH; i++) begin
      mirror[i] = '0; // Memory is blank after reset
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);

    for (int k = 0; k < NUM_CASES; k++) begin
      c      = cases[k];
      sat_hi = 0;
      sat_lo = 0;
      apply_config(c);
      for (int i = 0; i < int'(c.count); i++) begin
        if (c.sat) xs = i[0] ? -c.amp : c.amp;
        else xs = sample_t'($random(seed) % int'(c.amp));
        exp = expected_output(xs, mirror[ref_rd], ref_gain);
        drive_sample(xs);
        check_sample(y, exp, "filter output");
        if (k == 0 && i < int'(c.delay)) check_sample(y, xs, "pass-through output");
        if (y == S_MAX) sat_hi++;
        if (y == S_MIN) sat_lo++;
        mirror[ref_wr] = exp;
        ref_rd         = ref_rd + 1'b1; // Wraps at the line depth
        ref_wr         = ref_wr + 1'b1;
      end
      if (c.sat && (sat_hi == 0 || sat_lo == 0)) begin
        other_errors++;
        $display("Saturation case %0d did not reach both output limits", k);
      end
      // Last beat lands before the next case reads
      while (awvalid || wvalid) begin
        @(negedge clk);
      end
      repeat (4) @(negedge clk);
    end

    $display("Errors: %0d sample, %0d address, %0d other",
             sample_errors, addr_errors, other_errors);
    if (sample_errors + addr_errors + other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Address checks on every accepted request
  always @(posedge clk) begin
    if (rst_n) begin
      if (awvalid && awready) check_addr(aw.addr, 32'd8, "write");
      if (arvalid && arready) check_addr(ar.addr, 32'd64, "read");
      if (bready !== 1'b1) begin // Write responses always accepted
        other_errors++;
        $display("Error at time %0t: bready is %b, expected 1", $time, bready);
      end
    end
  end

  // Watchdog sized from the case table
  initial begin
    int limit;
    limit = 0;
    @(posedge rst_n);
    for (int k = 0; k < NUM_CASES; k++) begin
      limit += int'(cases[k].count);
    end
    limit = limit * CYCLES_EACH;
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("Test failed");
    $finish;
  end

endmodule

//--- project.f
+incdir+verilog
verilog/comb_pkg.sv
verilog/sync_fifo.sv
verilog/comb_core.sv
verilog/comb_mem_bridge.sv
verilog/iir_comb_top.sv
verif/comb_mem_model.sv
verif/tb_iir_comb.sv

//--- run.sh
#!/bin/sh
# Build and run the comb filter testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_iir_comb \
  -f project.f -o tb_iir_comb > build.log 2>&1 \
  && ./obj_dir/tb_iir_comb > sim.log 2>&1
cat build.log
cat sim.log 2>/dev/null
grep -q "^Test passed$" sim.log 2>/dev/null \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }
